//--- all.f
source/dmem_pkg.sv
source/data_ram.sv
source/spec_load_unit.sv
source/commit_unit.sv
source/resp_merge.sv
source/dmem_top.sv
verif/dmem_checker.sv
verif/dmem_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := dmem_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "Test passed" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/dmem_tb.sv
`timescale 1ns/1ps

module dmem_tb;

    import dmem_pkg::*;

    localparam int DEPTH_WORDS = 2048;
    localparam int CLK_PERIOD  = 40;
    localparam int TOTAL_REQ   = 40 + 92 + 5 + 5 + 48 + 24;  // Requests over all tests

    localparam mem_op_e LOAD_OPS [5]    = '{LB, LH, LW, LBU, LHU};
    localparam mem_op_e STORE_OPS [3]   = '{SB, SH, SW};
    localparam mem_op_e RECHECK_OPS [5] = '{LW, LHU, LBU, LH, LB};

    logic             clk;
    logic             reset;
    ls_req_t          ls_req;
    logic             ls_valid;
    logic             ls_ready;
    commit_req_t      cm_req;
    logic             cm_valid;
    logic             cm_ready;
    done_t            done;
    logic             done_valid;
    logic             done_ready;
    logic             flush;
    logic             bp_en;
    int               err_count;
    int               outstanding;
    logic [31:0]      lfsr_state;
    logic [TAG_W-1:0] ld_tag;
    logic [TAG_W-1:0] cm_tag;
    int               test_num;
    int               failed_tests;
    int               err_mark;

    dmem_top #(.DEPTH_WORDS(DEPTH_WORDS)) dut0 (
        .clk(clk), .reset(reset),
        .ls_req(ls_req), .ls_valid(ls_valid), .ls_ready(ls_ready),
        .cm_req(cm_req), .cm_valid(cm_valid), .cm_ready(cm_ready),
        .done(done), .done_valid(done_valid), .done_ready(done_ready)
    );

    dmem_checker #(.DEPTH_WORDS(DEPTH_WORDS)) chk0 (
        .clk(clk), .reset(reset),
        .ls_req(ls_req), .ls_valid(ls_valid), .ls_ready(ls_ready),
        .cm_req(cm_req), .cm_valid(cm_valid), .cm_ready(cm_ready),
        .done(done), .done_valid(done_valid), .done_ready(done_ready),
        .flush(flush), .err_count(err_count), .outstanding(outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (TOTAL_REQ * 200) @(posedge clk);
        $display("Timeout: run still busy after %0d cycles", TOTAL_REQ * 200);
        $display("Test failed");
        $finish;
    end

    // Random stalls on the completion stream
    initial begin
        logic [31:0] r;
        done_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (bp_en) begin
                take_bits(1, r);
                done_ready <= r[0];
            end else begin
                done_ready <= 1'b1;
            end
        end
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = next_lfsr(lfsr_state);
        end
    endtask

    function automatic logic [31:0] byte_addr(input int word, input logic [1:0] lane);
        logic [31:0] a;
        a      = 32'(word) << 2;
        a[1:0] = lane;
        return a;
    endfunction

    task automatic issue_load(input mem_op_e kind, input logic [31:0] address);
        ls_req   <= '{op: kind, addr: address, tag: ld_tag};
        ls_valid <= 1'b1;
        ld_tag    = ld_tag + TAG_W'(1);
        do begin
            @(posedge clk);
        end while (!ls_ready);
        ls_valid <= 1'b0;
    endtask

    task automatic send_commit(input mem_op_e kind, input logic [31:0] address,
                               input logic [31:0] value);
        cm_req   <= '{op: kind, addr: address, data: value, tag: cm_tag};
        cm_valid <= 1'b1;
        cm_tag    = cm_tag + TAG_W'(1);
        do begin
            @(posedge clk);
        end while (!cm_ready);
        cm_valid <= 1'b0;
    endtask

    // Drain, sweep for lost records, then report the test
    task automatic finish_test(input string name);
        int waited;
        int errs;
        waited = 0;
        @(posedge clk);
        while (outstanding != 0 && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(posedge clk);
        errs     = err_count - err_mark;
        err_mark = err_count;
        test_num++;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("test %0d (%s) finished with %0d errors", test_num, name, errs);
    endtask

    task automatic untouched_loads();
        logic [31:0] r;
        int          w;
        for (int n = 0; n < 8; n++) begin
            take_bits(11, r);
            w = int'(r[10:0]) % DEPTH_WORDS;
            for (int k = 0; k < 5; k++) begin
                take_bits(2, r);
                issue_load(LOAD_OPS[k], byte_addr(w, r[1:0]));
            end
        end
    endtask

    task automatic store_then_load();
        logic [31:0] r;
        logic [31:0] d;
        int          w;
        for (int n = 0; n < 4; n++) begin
            take_bits(10, r);
            w = int'(r[9:0]);  // Lower half, upper half stays untouched
            for (int k = 0; k < 3; k++) begin
                take_bits(32, d);
                take_bits(2, r);
                send_commit(STORE_OPS[2 - k], byte_addr(w, r[1:0]), d);  // SW first
            end
            for (int k = 0; k < 20; k++) begin
                issue_load(LOAD_OPS[k / 4], byte_addr(w, 2'(k % 4)));
            end
        end
    endtask

    // Untouched upper words hold index plus 3, so the top half is zero
    task automatic commit_recheck(input logic wrong);
        logic [31:0] r;
        logic [31:0] v;
        logic [31:0] carried;
        int          w;
        for (int i = 0; i < 5; i++) begin
            take_bits(10, r);
            w       = DEPTH_WORDS / 2 + int'(r[9:0]);
            v       = 32'(w + 3);
            carried = (i < 2) ? v : ((i == 2) ? (v >> 8) : 32'd0);
            if (wrong) begin
                take_bits(8, r);
                carried = carried ^ (r | 32'd1);
            end
            send_commit(RECHECK_OPS[i], byte_addr(w, 2'(i < 2 ? 0 : i - 1)), carried);
        end
    endtask

    task automatic backpressure_mix();
        bp_en <= 1'b1;
        fork
            begin : load_stream
                logic [31:0] r;
                logic [31:0] a;
                for (int n = 0; n < 24; n++) begin
                    take_bits(3, r);
                    take_bits(13, a);
                    issue_load(LOAD_OPS[int'(r[2:0]) % 5], byte_addr(int'(a[12:2]), a[1:0]));
                end
            end
            begin : commit_stream
                logic [31:0] r;
                logic [31:0] a;
                logic [31:0] d;
                for (int n = 0; n < 24; n++) begin
                    take_bits(3, r);
                    take_bits(13, a);
                    take_bits(32, d);
                    send_commit(r[2] ? LOAD_OPS[int'(r[1:0])] : STORE_OPS[int'(r[1:0]) % 3],
                                byte_addr(int'(a[12:2]), a[1:0]), d);
                end
            end
        join
        bp_en <= 1'b0;
    endtask

    task automatic same_word_race();
        logic [31:0] r;
        logic [31:0] d;
        int          w;
        for (int n = 0; n < 12; n++) begin
            take_bits(3, r);
            w = int'(r[2:0]);  // Few words, hit again and again
            take_bits(32, d);
            take_bits(5, r);
            fork
                issue_load(LOAD_OPS[int'(r[4:2]) % 5], byte_addr(w, r[1:0]));
                send_commit(STORE_OPS[int'(r[4:2]) % 3], byte_addr(w, r[1:0]), d);
            join
            repeat (2) @(posedge clk);  // Both units empty for the next pair
        end
    endtask

    initial begin
        reset        = 1'b1;
        ls_req       = '0;
        ls_valid     = 1'b0;
        cm_req       = '0;
        cm_valid     = 1'b0;
        flush        = 1'b0;
        bp_en        = 1'b0;
        lfsr_state   = 32'd42;
        ld_tag       = '0;
        cm_tag       = '0;
        test_num     = 0;
        failed_tests = 0;
        err_mark     = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        untouched_loads();
        finish_test("loads from untouched words");
        store_then_load();
        finish_test("stores then loads of every width and lane");
        commit_recheck(1'b0);
        finish_test("committed loads with matching value");
        commit_recheck(1'b1);
        finish_test("committed loads with wrong value");
        backpressure_mix();
        finish_test("random traffic under back-pressure");
        same_word_race();
        finish_test("same-cycle load and store to one word");
        $display("tests run: %0d, failing tests: %0d, errors: %0d",
                 test_num, failed_tests, err_count);
        if (failed_tests == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verif/dmem_checker.sv
`timescale 1ns/1ps

module dmem_checker #(
    parameter int DEPTH_WORDS = 2048
) (
    input  logic                  clk,
    input  logic                  reset,
    input  dmem_pkg::ls_req_t     ls_req,
    input  logic                  ls_valid,
    input  logic                  ls_ready,
    input  dmem_pkg::commit_req_t cm_req,
    input  logic                  cm_valid,
    input  logic                  cm_ready,
    input  dmem_pkg::done_t       done,
    input  logic                  done_valid,
    input  logic                  done_ready,
    input  logic                  flush,
    output int                    err_count,
    output int                    outstanding
);

    import dmem_pkg::*;

    localparam int NTAG = 2 ** TAG_W;

    logic [31:0] model [DEPTH_WORDS];  // Memory as the core should see it
    logic        pend [2][NTAG];       // Source first, then tag
    logic [31:0] exp_data [2][NTAG];
    logic        exp_exc [2][NTAG];
    int          acc_cycle [2][NTAG];
    int          cycle;
    int          errs;
    int          pend_cnt;

    // Lane shifted down to bit 0, then extended
    function automatic logic [31:0] expected_load(input logic [31:0] word,
                                                  input logic [31:0] addr,
                                                  input mem_op_e     op);
        logic [31:0] b;
        logic [31:0] h;
        b = (word >> {addr[1:0], 3'b000}) & 32'h0000_00ff;
        h = (word >> {addr[1], 4'b0000}) & 32'h0000_ffff;
        case (op)
            LB:      return b[7] ? (b | 32'hffff_ff00) : b;
            LH:      return h[15] ? (h | 32'hffff_0000) : h;
            LW:      return word;
            LBU:     return b;
            LHU:     return h;
            default: return 32'd0;
        endcase
    endfunction

    // Mask out the written lane, then OR in the new bytes
    function automatic logic [31:0] merged_store(input logic [31:0] old_word,
                                                 input logic [31:0] data,
                                                 input logic [31:0] addr,
                                                 input mem_op_e     op);
        logic [31:0] mask;
        logic [31:0] shift;
        mask  = 32'd0;
        shift = 32'd0;
        if (op == SB) begin
            mask  = 32'h0000_00ff;
            shift = {27'd0, addr[1:0], 3'd0};
        end else if (op == SH) begin
            mask  = 32'h0000_ffff;
            shift = {27'd0, addr[1], 4'd0};
        end else if (op == SW) begin
            mask = 32'hffff_ffff;
        end
        return (old_word & ~(mask << shift)) | ((data & mask) << shift);
    endfunction

    function automatic string source_name(input int s);
        if (s != 0) begin
            return "commit";
        end
        return "load";
    endfunction

    task automatic expect_done(input int s, input int t, input logic [31:0] data,
                               input logic exc);
        if (pend[s][t]) begin
            $display("Tag reuse at %0t ns: %s tag %0d accepted again while in flight",
                     $time, source_name(s), t);
            errs++;
        end else begin
            pend_cnt++;
        end
        pend[s][t]      = 1'b1;
        exp_data[s][t]  = data;
        exp_exc[s][t]   = exc;
        acc_cycle[s][t] = cycle;
    endtask

    always @(posedge clk) begin : compare
        int          idx;
        int          s;
        int          t;
        logic [31:0] val;
        if (reset) begin
            for (int i = 0; i < DEPTH_WORDS; i++) begin
                model[i] = 32'(i + 3);
            end
            for (int k = 0; k < NTAG; k++) begin
                pend[0][k] = 1'b0;
                pend[1][k] = 1'b0;
            end
            pend_cnt = 0;
            errs     = 0;
            cycle    = 0;
        end else begin
            cycle++;
            // Completions first since a tag may come back and be reused at one edge
            if (done_valid && done_ready) begin
                s = int'(done.source);
                t = int'(done.tag);
                if (!pend[s][t]) begin
                    $display("Extra completion at %0t ns: %s tag %0d was not in flight",
                             $time, source_name(s), t);
                    errs++;
                end else begin
                    if (done.data !== exp_data[s][t] || done.exception !== exp_exc[s][t]) begin
                        $display("error at %0t ns: %s tag %0d gave %h exc %b, expected %h exc %b",
                                 $time, source_name(s), t, done.data, done.exception,
                                 exp_data[s][t], exp_exc[s][t]);
                        errs++;
                    end
                    for (int k = 0; k < NTAG; k++) begin
                        if (s == 0 && pend[1][k] && acc_cycle[1][k] <= acc_cycle[0][t]) begin
                            $display("Order broken at %0t ns: load tag %0d passed commit tag %0d",
                                     $time, t, k);
                            errs++;
                        end
                    end
                    pend[s][t] = 1'b0;
                    pend_cnt--;
                end
            end
            if (ls_valid && ls_ready) begin
                idx = int'((ls_req.addr >> 2) % DEPTH_WORDS);
                expect_done(0, int'(ls_req.tag),
                            expected_load(model[idx], ls_req.addr, ls_req.op), 1'b0);
            end
            // Commit after the load, so a same-cycle load sees the old word
            if (cm_valid && cm_ready) begin
                idx = int'((cm_req.addr >> 2) % DEPTH_WORDS);
                if (cm_req.op inside {SB, SH, SW}) begin
                    expect_done(1, int'(cm_req.tag), 32'd0, 1'b0);
                    model[idx] = merged_store(model[idx], cm_req.data, cm_req.addr, cm_req.op);
                end else begin
                    val = expected_load(model[idx], cm_req.addr, cm_req.op);
                    expect_done(1, int'(cm_req.tag), val, val != cm_req.data);
                end
            end
            if (flush) begin
                for (int k = 0; k < 2 * NTAG; k++) begin
                    if (pend[k / NTAG][k % NTAG]) begin
                        $display("Missing completion: %s tag %0d never came back",
                                 source_name(k / NTAG), k % NTAG);
                        pend[k / NTAG][k % NTAG] = 1'b0;
                        pend_cnt--;
                        errs++;
                    end
                end
            end
        end
        err_count   <= errs;
        outstanding <= pend_cnt;
    end

endmodule

//--- source/dmem_top.sv
`timescale 1ns/1ps

module dmem_top #(
    parameter int DEPTH_WORDS = 2048
) (
    input  logic                  clk,
    input  logic                  reset,
    input  dmem_pkg::ls_req_t     ls_req,
    input  logic                  ls_valid,
    output logic                  ls_ready,
    input  dmem_pkg::commit_req_t cm_req,
    input  logic                  cm_valid,
    output logic                  cm_ready,
    output dmem_pkg::done_t       done,
    output logic                  done_valid,
    input  logic                  done_ready
);

    import dmem_pkg::*;

    logic [31:0] ld_raddr;
    logic [31:0] ld_rdata;
    logic [31:0] cm_raddr;
    logic [31:0] cm_rdata;
    logic        ram_we;
    logic [31:0] ram_waddr;
    logic [31:0] ram_wdata;

    done_t       ld_done;
    logic        ld_done_valid;
    logic        ld_done_ready;
    done_t       cm_done;
    logic        cm_done_valid;
    logic        cm_done_ready;

    data_ram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) ram0 (
        .clk     (clk),
        .reset   (reset),
        .we      (ram_we),
        .waddr   (ram_waddr),
        .wdata   (ram_wdata),
        .raddr_a (ld_raddr),
        .raddr_b (cm_raddr),
        .rdata_a (ld_rdata),
        .rdata_b (cm_rdata)
    );

    spec_load_unit ld0 (
        .clk       (clk),
        .reset     (reset),
        .req       (ls_req),
        .req_valid (ls_valid),
        .req_ready (ls_ready),
        .raddr     (ld_raddr),
        .rdata     (ld_rdata),
        .out       (ld_done),
        .out_ready (ld_done_ready),
        .out_valid (ld_done_valid)
    );

    commit_unit cm0 (
        .clk       (clk),
        .reset     (reset),
        .req       (cm_req),
        .req_valid (cm_valid),
        .req_ready (cm_ready),
        .raddr     (cm_raddr),
        .rdata     (cm_rdata),
        .we        (ram_we),
        .waddr     (ram_waddr),
        .wdata     (ram_wdata),
        .out       (cm_done),
        .out_valid (cm_done_valid),
        .out_ready (cm_done_ready)
    );

    resp_merge mrg0 (
        .clk       (clk),
        .reset     (reset),
        .ld_in     (ld_done),
        .cm_in     (cm_done),
        .ld_valid  (ld_done_valid),
        .cm_valid  (cm_done_valid),
        .ld_ready  (ld_done_ready),
        .cm_ready  (cm_done_ready),
        .out       (done),
        .out_valid (done_valid),
        .out_ready (done_ready)
    );

endmodule

//--- source/resp_merge.sv
`timescale 1ns/1ps

module resp_merge (
    input  logic            clk,
    input  logic            reset,
    input  dmem_pkg::done_t ld_in,
    input  dmem_pkg::done_t cm_in,
    input  logic            ld_valid,
    input  logic            cm_valid,
    output logic            ld_ready,
    output logic            cm_ready,
    output dmem_pkg::done_t out,
    output logic            out_valid,
    input  logic            out_ready
);

    logic take;

    // Output slot empty or draining
    assign take = !out_valid || out_ready;

    // Commits first since they hold up retirement
    assign cm_ready = take;
    assign ld_ready = take && !cm_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= cm_valid || ld_valid;
        end
    end

    // Held stable while blocked
    always_ff @(posedge clk) begin
        if (take) begin
            if (cm_valid) begin
                out <= cm_in;
            end else if (ld_valid) begin
                out <= ld_in;
            end
        end
    end

endmodule

//--- source/commit_unit.sv
`timescale 1ns/1ps

module commit_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  dmem_pkg::commit_req_t req,
    input  logic                 req_valid,
    output logic                 req_ready,
    output logic [31:0]          raddr,
    input  logic [31:0]          rdata,
    output logic                 we,
    output logic [31:0]          waddr,
    output logic [31:0]          wdata,
    output dmem_pkg::done_t      out,
    output logic                 out_valid,
    input  logic                 out_ready
);

    import dmem_pkg::*;

    logic        accept;
    logic        is_store;
    logic [31:0] reload_val;
    logic        mismatch;

    assign req_ready = !out_valid || out_ready;
    assign accept    = req_valid && req_ready;
    assign is_store  = req.op inside {SB, SH, SW};

    // Port B serves both the store merge and the load re-check
    assign raddr = req.addr;

    // Store goes to memory at the accepting edge
    assign we    = accept && is_store;
    assign waddr = req.addr;
    assign wdata = store_merge(rdata, req.data, req.addr[1:0], req.op);

    // Committed load compared against what the core got speculatively
    assign reload_val = load_extract(rdata, req.addr[1:0], req.op);
    assign mismatch   = !is_store && (reload_val != req.data);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out.source    <= SRC_COMMIT;
            out.tag       <= req.tag;
            out.data      <= is_store ? 32'd0 : reload_val;  // Stores report zero
            out.exception <= mismatch;  // Memory-ordering violation
        end
    end

endmodule

//--- source/spec_load_unit.sv
`timescale 1ns/1ps

module spec_load_unit (
    input  logic             clk,
    input  logic             reset,
    input  dmem_pkg::ls_req_t req,
    input  logic             req_valid,
    output logic             req_ready,
    output logic [31:0]      raddr,
    input  logic [31:0]      rdata,
    output dmem_pkg::done_t  out,
    input  logic             out_ready,
    output logic             out_valid
);

    import dmem_pkg::*;

    logic        accept;
    logic [31:0] load_val;

    // Free slot, or the held record leaves this cycle
    assign req_ready = !out_valid || out_ready;
    assign accept    = req_valid && req_ready;

    assign raddr    = req.addr;  // Port A, combinational
    assign load_val = load_extract(rdata, req.addr[1:0], req.op);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // Drained with nothing behind it
        end
    end

    // Payload only loads on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            out.source    <= SRC_LOAD;
            out.tag       <= req.tag;
            out.data      <= load_val;
            out.exception <= 1'b0;  // Speculative loads never fault here
        end
    end

endmodule

//--- source/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int DEPTH_WORDS = 2048
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic [31:0] waddr,
    input  logic [31:0] wdata,
    input  logic [31:0] raddr_a,
    input  logic [31:0] raddr_b,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b
);

    localparam int AW = $clog2(DEPTH_WORDS);

    logic [31:0]   mem [DEPTH_WORDS];
    logic [AW-1:0] widx;
    logic [AW-1:0] ridx_a;
    logic [AW-1:0] ridx_b;

    // Byte address to word index, upper bits wrap
    assign widx   = waddr[AW+1:2];
    assign ridx_a = raddr_a[AW+1:2];
    assign ridx_b = raddr_b[AW+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH_WORDS; i++) begin
                mem[i] <= 32'(i + 3);  // Known pattern for the core's boot code
            end
        end else if (we) begin
            mem[widx] <= wdata;  // Full word, lanes merged upstream
        end
    end

    // Both reads see the word before this edge's write
    assign rdata_a = mem[ridx_a];
    assign rdata_b = mem[ridx_b];

endmodule

//--- source/dmem_pkg.sv
package dmem_pkg;

    localparam int TAG_W = 6;

    // Store bit on top of funct3
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } mem_op_e;

    typedef enum logic {
        SRC_LOAD   = 1'b0,
        SRC_COMMIT = 1'b1
    } src_e;

    typedef struct packed {
        mem_op_e            op;
        logic [31:0]        addr;
        logic [TAG_W-1:0]   tag;
    } ls_req_t;

    typedef struct packed {
        mem_op_e            op;
        logic [31:0]        addr;
        logic [31:0]        data;  // Store data or speculative load value
        logic [TAG_W-1:0]   tag;
    } commit_req_t;

    typedef struct packed {
        src_e               source;
        logic [TAG_W-1:0]   tag;
        logic [31:0]        data;
        logic               exception;
    } done_t;

    // Picks the lane out of a word and extends it to 32 bits
    function automatic logic [31:0] load_extract(input logic [31:0] word,
                                                 input logic [1:0]  lane,
                                                 input mem_op_e     op);
        logic [7:0]  byte_val;
        logic [15:0] half_val;
        byte_val = word[{lane, 3'b000} +: 8];
        half_val = lane[1] ? word[31:16] : word[15:0];  // Halves use lane bit 1 only
        case (op)
            LB:      return {{24{byte_val[7]}}, byte_val};
            LH:      return {{16{half_val[15]}}, half_val};
            LW:      return word;
            LBU:     return {24'd0, byte_val};
            LHU:     return {16'd0, half_val};
            default: return 32'd0;  // Store ops carry no load value
        endcase
    endfunction

    // Writes the store lane into the old word
    function automatic logic [31:0] store_merge(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [1:0]  lane,
                                                input mem_op_e     op);
        logic [31:0] word;
        word = old_word;
        case (op)
            SB:      word[{lane, 3'b000} +: 8] = data[7:0];
            SH:      word[{lane[1], 4'b0000} +: 16] = data[15:0];
            SW:      word = data;
            default: word = old_word;
        endcase
        return word;
    endfunction

endpackage
